// File: dino_runner.f
+incdir+hdl
hdl/uart_pkg.sv
hdl/game_pkg.sv
hdl/uart_cmd_rx.sv
hdl/runner_physics.sv
hdl/score_keeper.sv
hdl/score_display.sv
hdl/dino_runner.sv
dv/tb_clock_gen.sv
dv/dino_runner_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the dino_runner testbench with Verilator.
# Exits non-zero when a step fails or the log holds the fail message.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module dino_runner_tb -f dino_runner.f \
	--Mdir "$BUILD_DIR" -o dino_runner_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/dino_runner_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
	exit 1
fi
exit 0

// File: dv/dino_runner_tb.sv
`include "dino_runner_cfg.svh"

module dino_runner_tb;

	localparam int DRIVE_DLY = 10;
	localparam int TICK = `DR_TICK_DIV;
	localparam int BIT_CLKS = 16 * (`DR_CLK_HZ / (`DR_BAUD * 16));
	localparam int GROUND = `DR_GROUND_Y;
	localparam int APEX = `DR_GROUND_Y - `DR_JUMP_FORCE * (`DR_JUMP_FORCE + 1) / 2;
	localparam int X_WRAP = `DR_XSCREEN - `DR_BOX;
	localparam int SPAN = `DR_RESPAWN_SPAN;
	localparam int LAP_LOW = 50;
	localparam int LAP_HIGH = 250;
	localparam int N_APPROACH = 12;
	// Longest lap is a far respawn back to the dinosaur
	localparam int LAP_CYCLES = (`DR_XSCREEN + `DR_RESPAWN_SPAN) * TICK;
	localparam int TIMEOUT_CYCLES = (N_APPROACH + 3) * LAP_CYCLES + 20 * BIT_CLKS + 200 * TICK;

	logic Clock;
	logic por_n;
	logic test_rst_n;
	logic rst_n;
	logic uart_rx;
	logic jump_btn;
	game_pkg::seg7_t hex0;
	game_pkg::seg7_t hex1;
	game_pkg::seg7_t hex2;
	game_pkg::seg7_t hex3;
	game_pkg::seg7_t hex4;
	game_pkg::seg7_t hex5;
	logic game_over;
	game_pkg::y_coord_t dino_y;
	game_pkg::x_coord_t obstacle_x;

	// Model state holds what the DUT should show after the coming rising edge
	logic m_go;
	logic m_go_d;
	logic m_prev_coll;
	logic m_lap;
	int m_prev_x;
	int m_score;
	int m_best = 0; // High score survives rst_n
	int m_passes = 0;
	int low_y;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	assign rst_n = por_n & test_rst_n;

	tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(3), .DRIVE_DLY(DRIVE_DLY)) i_clock_gen (
		.Clock (Clock),
		.rst_n (por_n)
	);

	dino_runner i_dino_runner (
		.Clock      (Clock),
		.rst_n      (rst_n),
		.uart_rx    (uart_rx),
		.jump_btn   (jump_btn),
		.hex0       (hex0),
		.hex1       (hex1),
		.hex2       (hex2),
		.hex3       (hex3),
		.hex4       (hex4),
		.hex5       (hex5),
		.game_over  (game_over),
		.dino_y     (dino_y),
		.obstacle_x (obstacle_x)
	);

	// Reference model steps on stable positions mid-cycle
	always @(negedge Clock) begin
		int dx;
		int dy;
		logic coll;
		logic pass;
		if (!rst_n) begin
			m_go = 1'b0;
			m_go_d = 1'b0;
			m_prev_coll = 1'b0;
			m_lap = 1'b0;
			m_prev_x = `DR_XSCREEN;
			m_score = 0;
		end else begin
			dx = int'(obstacle_x) - `DR_DINO_X;
			if (dx < 0)
				dx = -dx;
			dy = int'(dino_y) - `DR_OBST_Y;
			if (dy < 0)
				dy = -dy;
			coll = (dx <= `DR_HB_W) && (dy <= `DR_HB_H);
			pass = (m_prev_x > `DR_DINO_X) && (obstacle_x <= `DR_DINO_X) && !m_lap;
			if (m_go && !m_go_d && m_score > m_best)
				m_best = m_score; // Rising game over
			m_go_d = m_go;
			if (!m_go) begin
				if (pass) begin
					m_lap = 1'b1;
					if (!coll && !m_prev_coll) begin
						m_score++;
						m_passes++;
					end
				end
				if (m_prev_x < LAP_LOW && obstacle_x > LAP_HIGH)
					m_lap = 1'b0; // New lap after the left edge wrap
			end
			m_go = m_go | coll;
			m_prev_coll = coll;
			m_prev_x = obstacle_x;
			if (dino_y < low_y)
				low_y = dino_y;
		end
	end

	always @(posedge Clock) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Run stopped by the timeout after %0d cycles with %0d errors",
				cycles, errors);
			$display("** FAIL **");
			$finish;
		end
	end

	task automatic next_cycles(input int n);
		repeat (n) begin
			@(posedge Clock);
			#DRIVE_DLY;
		end
	endtask

	task automatic pulse_reset();
		test_rst_n = 1'b0;
		next_cycles(3);
		test_rst_n = 1'b1;
		next_cycles(1);
	endtask

	// 8N1 frame sent LSB first
	task automatic send_byte(input logic [7:0] data);
		logic [9:0] frame;
		frame = {1'b1, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			uart_rx = frame[i];
			next_cycles(BIT_CLKS);
		end
	endtask

	// Returns early when the model predicts a game over
	task automatic wait_obstacle(input int col, input int limit, output bit reached);
		int n;
		n = 0;
		reached = 1'b0;
		while (!reached && !m_go && n < limit) begin
			next_cycles(1);
			n++;
			reached = (obstacle_x == col);
		end
	endtask

	function automatic game_pkg::seg7_t digit_pattern(input int d);
		logic [6:0] lit; // Lit segments from g down to a
		case (d)
			0: lit = 7'h3F;
			1: lit = 7'h06;
			2: lit = 7'h5B;
			3: lit = 7'h4F;
			4: lit = 7'h66;
			5: lit = 7'h6D;
			6: lit = 7'h7D;
			7: lit = 7'h07;
			8: lit = 7'h7F;
			9: lit = 7'h6F;
			default: lit = 7'h00;
		endcase
		return ~lit;
	endfunction

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		if (expected != actual) begin
			errors++;
			$display("ERROR t=%0t %s expected %0d actual %0d", $time, name, expected, actual);
		end
	endtask

	task automatic check_seg(input string name, input int digit, input game_pkg::seg7_t actual);
		checks++;
		if (digit_pattern(digit) != actual) begin
			errors++;
			$display("ERROR t=%0t %s expected %b actual %b", $time, name,
				digit_pattern(digit), actual);
		end
	endtask

	task automatic check_display(input string name, input int value, input game_pkg::seg7_t ones,
			input game_pkg::seg7_t tens, input game_pkg::seg7_t hundreds);
		check_seg({name, " ones"}, value % 10, ones);
		check_seg({name, " tens"}, (value / 10) % 10, tens);
		check_seg({name, " hundreds"}, (value / 100) % 10, hundreds);
	endtask

	initial begin
		logic [7:0] rnd_byte;
		int ahead;
		int passes_before;
		int last_score;
		int expected_high;
		bit found;
		uart_rx = 1'b1;
		jump_btn = 1'b0;
		test_rst_n = 1'b1;
		low_y = GROUND;
		void'($urandom(58));

		// Reset state
		@(posedge por_n);
		next_cycles(1);
		check_value("game_over", 0, game_over);
		check_value("dino_y", GROUND, dino_y);
		check_value("obstacle_x", `DR_XSCREEN, obstacle_x);
		check_display("score", 0, hex0, hex1, hex2);
		check_display("high score", 0, hex3, hex4, hex5);

		// Jump from the serial command
		low_y = GROUND;
		send_byte(`DR_CMD_JUMP);
		found = 1'b0;
		for (int n = 0; n < 60 * TICK && !found; n++) begin
			next_cycles(1);
			found = (low_y < GROUND) && (dino_y == GROUND);
		end
		if (!found) begin
			errors++;
			$display("The jump after the UART command did not start or did not land in time");
		end
		check_value("lowest dino_y", APEX, low_y);
		check_value("game_over", m_go, game_over);

		// Other bytes must not jump
		pulse_reset();
		low_y = GROUND;
		repeat (2) begin
			rnd_byte = 8'($urandom_range(255, 0));
			while (rnd_byte == `DR_CMD_JUMP)
				rnd_byte = 8'($urandom_range(255, 0));
			send_byte(rnd_byte);
		end
		next_cycles(40 * TICK);
		check_value("lowest dino_y", GROUND, low_y);
		check_value("game_over", m_go, game_over);

		// Scoring laps with a button jump
		pulse_reset();
		for (int lap = 0; lap < N_APPROACH; lap++) begin
			ahead = $urandom_range(16, 12);
			passes_before = m_passes;
			wait_obstacle(`DR_DINO_X + ahead, LAP_CYCLES, found);
			if (m_go)
				break;
			if (!found) begin
				errors++;
				$display("The obstacle never came %0d columns ahead of the dinosaur", ahead);
				break;
			end
			jump_btn = 1'b1;
			next_cycles(4);
			jump_btn = 1'b0;
			wait_obstacle(`DR_DINO_X, 40 * TICK, found);
			if (m_go)
				break;
			if (!found) begin
				errors++;
				$display("The obstacle never reached the dinosaur column");
				break;
			end
			next_cycles(TICK);
			check_display("score", m_score, hex0, hex1, hex2);
			if (m_passes != passes_before) begin
				checks++;
				if (obstacle_x < X_WRAP - 1 || obstacle_x >= X_WRAP + SPAN) begin
					errors++;
					$display("Obstacle at column %0d outside the respawn range",
						obstacle_x);
				end
			end
		end

		// Game over forced by a standing dinosaur if no jump failed
		if (!m_go)
			wait_obstacle(-1, 2 * LAP_CYCLES, found);
		if (!m_go) begin
			errors++;
			$display("The obstacle never collided with the dinosaur");
		end
		check_value("game_over", 1, game_over);
		last_score = m_score;
		next_cycles(2);
		repeat (100) begin
			next_cycles(TICK);
			check_value("game_over", 1, game_over);
			check_value("dino_y", GROUND, dino_y);
			check_value("obstacle_x", `DR_XSCREEN, obstacle_x);
			check_display("score", last_score, hex0, hex1, hex2);
		end

		// High score kept across reset
		expected_high = m_best;
		pulse_reset();
		check_value("game_over", 0, game_over);
		check_value("dino_y", GROUND, dino_y);
		check_value("obstacle_x", `DR_XSCREEN, obstacle_x);
		check_display("score", 0, hex0, hex1, hex2);
		check_display("high score", expected_high, hex3, hex4, hex5);

		$display("Checks: %0d, errors: %0d, final score %0d", checks, errors, last_score);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: dv/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 3,
	parameter int DRIVE_DLY = 10
) (
	output logic Clock,
	output logic rst_n
);

	initial begin
		Clock = 1'b0;
		forever #(PERIOD / 2) Clock = ~Clock;
	end

	// Power-on reset, released just after a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clock);
		#DRIVE_DLY rst_n = 1'b1;
	end

endmodule

// File: hdl/dino_runner.sv
module dino_runner (
	input  logic Clock,
	input  logic rst_n,
	input  logic uart_rx,
	input  logic jump_btn,
	output game_pkg::seg7_t hex0,
	output game_pkg::seg7_t hex1,
	output game_pkg::seg7_t hex2,
	output game_pkg::seg7_t hex3,
	output game_pkg::seg7_t hex4,
	output game_pkg::seg7_t hex5,
	output logic game_over,
	output game_pkg::y_coord_t dino_y,
	output game_pkg::x_coord_t obstacle_x
);

	logic jump_cmd;
	logic respawn;
	game_pkg::score_t score;
	game_pkg::score_t high_score;

	// Serial command decode
	uart_cmd_rx i_uart_cmd_rx (
		.Clock    (Clock),
		.rst_n    (rst_n),
		.uart_rx  (uart_rx),
		.jump_cmd (jump_cmd)
	);

	runner_physics i_runner_physics (
		.Clock      (Clock),
		.rst_n      (rst_n),
		.jump_cmd   (jump_cmd),
		.jump_btn   (jump_btn),
		.respawn    (respawn),
		.game_over  (game_over),
		.dino_y     (dino_y),
		.obstacle_x (obstacle_x)
	);

	score_keeper i_score_keeper (
		.Clock      (Clock),
		.rst_n      (rst_n),
		.dino_y     (dino_y),
		.obstacle_x (obstacle_x),
		.score      (score),
		.high_score (high_score),
		.respawn    (respawn),
		.game_over  (game_over)
	);

	score_display i_score_display (
		.value    (score),
		.ones     (hex0),
		.tens     (hex1),
		.hundreds (hex2)
	);

	// High score on the left three digits
	score_display i_high_display (
		.value    (high_score),
		.ones     (hex3),
		.tens     (hex4),
		.hundreds (hex5)
	);

endmodule

// File: hdl/score_display.sv
module score_display (
	input  game_pkg::score_t value,
	output game_pkg::seg7_t ones,
	output game_pkg::seg7_t tens,
	output game_pkg::seg7_t hundreds
);

	logic [3:0] d_ones;
	logic [3:0] d_tens;
	logic [3:0] d_hundreds;

	// Standard active-low digit patterns
	function automatic game_pkg::seg7_t seg_of(input logic [3:0] digit);
		case (digit)
			4'd0: return 7'b1000000;
			4'd1: return 7'b1111001;
			4'd2: return 7'b0100100;
			4'd3: return 7'b0110000;
			4'd4: return 7'b0011001;
			4'd5: return 7'b0010010;
			4'd6: return 7'b0000010;
			4'd7: return 7'b1111000;
			4'd8: return 7'b0000000;
			4'd9: return 7'b0010000;
			default: return 7'b1111111; // Blank
		endcase
	endfunction

	// Thousands and up are not shown
	assign d_ones = 4'(value % 16'd10);
	assign d_tens = 4'((value / 16'd10) % 16'd10);
	assign d_hundreds = 4'((value / 16'd100) % 16'd10);

	assign ones = seg_of(d_ones);
	assign tens = seg_of(d_tens);
	assign hundreds = seg_of(d_hundreds);

endmodule

// File: hdl/score_keeper.sv
`include "dino_runner_cfg.svh"

module score_keeper (
	input  logic Clock,
	input  logic rst_n,
	input  game_pkg::y_coord_t dino_y,
	input  game_pkg::x_coord_t obstacle_x,
	output game_pkg::score_t score,
	output game_pkg::score_t high_score,
	output logic respawn,
	output logic game_over
);

	localparam game_pkg::x_coord_t DINO_X = game_pkg::x_coord_t'(`DR_DINO_X);
	localparam game_pkg::x_coord_t X_START = game_pkg::x_coord_t'(`DR_XSCREEN);
	localparam game_pkg::x_coord_t HB_W = game_pkg::x_coord_t'(`DR_HB_W);
	localparam game_pkg::y_coord_t OBST_Y = game_pkg::y_coord_t'(`DR_OBST_Y);
	localparam game_pkg::y_coord_t HB_H = game_pkg::y_coord_t'(`DR_HB_H);
	localparam game_pkg::x_coord_t LAP_LOW = 9'd50;
	localparam game_pkg::x_coord_t LAP_HIGH = 9'd250;

	game_pkg::x_coord_t dx;
	game_pkg::y_coord_t dy;
	game_pkg::x_coord_t prev_x;
	logic collision;
	logic prev_collision;
	logic lap_scored;
	logic pass;
	logic game_over_d;
	game_pkg::score_t best = '0; // Kept across rst_n

	// Absolute distances between the two boxes
	assign dx = (obstacle_x >= DINO_X) ? obstacle_x - DINO_X : DINO_X - obstacle_x;
	assign dy = (dino_y >= OBST_Y) ? dino_y - OBST_Y : OBST_Y - dino_y;
	assign collision = (dx <= HB_W) && (dy <= HB_H);

	// Obstacle crosses the dino column
	assign pass = (prev_x > DINO_X) && (obstacle_x <= DINO_X) && !lap_scored;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			game_over <= 1'b0;
			game_over_d <= 1'b0;
			prev_collision <= 1'b0;
			prev_x <= X_START;
			lap_scored <= 1'b0;
			score <= '0;
			respawn <= 1'b0;
		end else begin
			game_over <= game_over | collision; // Sticky until rst_n
			game_over_d <= game_over;
			prev_collision <= collision;
			prev_x <= obstacle_x;
			respawn <= 1'b0;
			if (!game_over) begin
				if (pass) begin
					lap_scored <= 1'b1;
					if (!collision && !prev_collision) begin
						score <= score + 1'b1;
						respawn <= 1'b1;
					end
				end
				// Wrap from the left edge starts a new lap
				if (prev_x < LAP_LOW && obstacle_x > LAP_HIGH)
					lap_scored <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (game_over && !game_over_d && score > best)
			best <= score;
	end

	assign high_score = best;

	a_score_frozen: assert property (@(posedge Clock) disable iff (!rst_n)
		game_over |=> $stable(score));

endmodule

// File: hdl/runner_physics.sv
`include "dino_runner_cfg.svh"

module runner_physics (
	input  logic Clock,
	input  logic rst_n,
	input  logic jump_cmd,
	input  logic jump_btn,
	input  logic respawn,
	input  logic game_over,
	output game_pkg::y_coord_t dino_y,
	output game_pkg::x_coord_t obstacle_x
);

	localparam int TICK_W = $clog2(`DR_TICK_DIV);
	localparam game_pkg::y_coord_t GROUND_Y = game_pkg::y_coord_t'(`DR_GROUND_Y);
	localparam game_pkg::x_coord_t X_START = game_pkg::x_coord_t'(`DR_XSCREEN);
	localparam game_pkg::x_coord_t X_WRAP = game_pkg::x_coord_t'(`DR_XSCREEN - `DR_BOX);
	localparam game_pkg::x_coord_t SPAN = game_pkg::x_coord_t'(`DR_RESPAWN_SPAN);
	localparam game_pkg::velocity_t JUMP_VEL = -game_pkg::velocity_t'(`DR_JUMP_FORCE);
	localparam game_pkg::velocity_t GRAVITY = game_pkg::velocity_t'(`DR_GRAVITY);

	logic btn_meta;
	logic btn_sync;
	logic jump_req;
	logic [TICK_W-1:0] tick_cnt;
	logic game_tick;
	logic [15:0] lfsr;
	logic lfsr_fb;
	game_pkg::jump_state_e jump_state;
	game_pkg::velocity_t velocity;
	logic signed [10:0] next_y;
	game_pkg::x_coord_t respawn_x;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			btn_meta <= 1'b0;
			btn_sync <= 1'b0;
		end else begin
			btn_meta <= jump_btn;
			btn_sync <= btn_meta;
		end
	end

	assign jump_req = jump_cmd | btn_sync;

	// Slow game tick
	assign game_tick = (tick_cnt == TICK_W'(`DR_TICK_DIV - 1));

	always_ff @(posedge Clock) begin
		if (!rst_n || game_tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// Taps 15, 14, 12, 3
	assign lfsr_fb = lfsr[15] ^ lfsr[14] ^ lfsr[12] ^ lfsr[3];

	always_ff @(posedge Clock) begin
		if (!rst_n)
			lfsr <= `DR_LFSR_SEED;
		else
			lfsr <= {lfsr[14:0], lfsr_fb};
	end

	assign next_y = $signed({3'b000, dino_y}) + velocity;
	assign respawn_x = X_WRAP + (lfsr[8:0] % SPAN);

	always_ff @(posedge Clock) begin
		if (!rst_n || game_over) begin
			jump_state <= game_pkg::RUNNING;
			velocity <= '0;
			dino_y <= GROUND_Y;
		end else if (jump_req && jump_state == game_pkg::RUNNING) begin
			velocity <= JUMP_VEL; // Launch now, move on next tick
			jump_state <= game_pkg::AIRBORNE;
		end else if (game_tick && jump_state == game_pkg::AIRBORNE) begin
			if (next_y >= `DR_GROUND_Y) begin
				// Landed
				dino_y <= GROUND_Y;
				velocity <= '0;
				jump_state <= game_pkg::RUNNING;
			end else begin
				dino_y <= next_y[7:0];
				velocity <= velocity + GRAVITY;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n || game_over)
			obstacle_x <= X_START;
		else if (respawn)
			obstacle_x <= respawn_x;
		else if (game_tick) begin
			if (obstacle_x <= 9'd1)
				obstacle_x <= X_WRAP; // Left edge wrap
			else
				obstacle_x <= obstacle_x - 1'b1;
		end
	end

	a_dino_above_ground: assert property (@(posedge Clock) disable iff (!rst_n)
		dino_y <= GROUND_Y);

endmodule

// File: hdl/uart_cmd_rx.sv
`include "dino_runner_cfg.svh"

module uart_cmd_rx (
	input  logic Clock,
	input  logic rst_n,
	input  logic uart_rx,
	output logic jump_cmd
);

	localparam int DIV = `DR_CLK_HZ / (`DR_BAUD * 16);
	localparam int DIV_W = $clog2(DIV);

	logic [DIV_W-1:0] div_cnt;
	logic tick_16x;
	logic rx_meta;
	logic rx_sync;
	uart_pkg::rx_state_e state;
	logic [3:0] os_cnt;
	logic [2:0] bit_idx;
	uart_pkg::byte_t shift_reg;
	uart_pkg::byte_t rx_byte;
	logic byte_valid;

	// 16x oversampling tick
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			div_cnt <= '0;
			tick_16x <= 1'b0;
		end else if (div_cnt == DIV_W'(DIV - 1)) begin
			div_cnt <= '0;
			tick_16x <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			tick_16x <= 1'b0;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_meta <= 1'b1; // Line idles high
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state <= uart_pkg::RX_IDLE;
			os_cnt <= '0;
			bit_idx <= '0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			if (tick_16x) begin
				case (state)
					uart_pkg::RX_IDLE: begin
						if (!rx_sync) begin
							state <= uart_pkg::RX_START;
							os_cnt <= 4'd7; // Half a bit to mid start
						end
					end
					uart_pkg::RX_START: begin
						if (os_cnt != 4'd0)
							os_cnt <= os_cnt - 1'b1;
						else if (!rx_sync) begin
							state <= uart_pkg::RX_DATA;
							os_cnt <= 4'd15;
							bit_idx <= '0;
						end else
							state <= uart_pkg::RX_IDLE; // Glitch, not a start bit
					end
					uart_pkg::RX_DATA: begin
						if (os_cnt != 4'd0)
							os_cnt <= os_cnt - 1'b1;
						else begin
							os_cnt <= 4'd15;
							if (bit_idx == 3'd7)
								state <= uart_pkg::RX_STOP;
							else
								bit_idx <= bit_idx + 1'b1;
						end
					end
					uart_pkg::RX_STOP: begin
						if (os_cnt != 4'd0)
							os_cnt <= os_cnt - 1'b1;
						else begin
							state <= uart_pkg::RX_IDLE;
							byte_valid <= rx_sync; // Framing error drops the byte
						end
					end
					default: state <= uart_pkg::RX_IDLE;
				endcase
			end
		end
	end

	// Data bits arrive LSB first
	always_ff @(posedge Clock) begin
		if (tick_16x && os_cnt == 4'd0) begin
			if (state == uart_pkg::RX_DATA)
				shift_reg <= {rx_sync, shift_reg[7:1]};
			if (state == uart_pkg::RX_STOP)
				rx_byte <= shift_reg;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n)
			jump_cmd <= 1'b0;
		else
			jump_cmd <= byte_valid && (rx_byte == `DR_CMD_JUMP);
	end

	a_jump_cmd_pulse: assert property (@(posedge Clock) disable iff (!rst_n)
		jump_cmd |=> !jump_cmd);

endmodule

// File: hdl/game_pkg.sv
package game_pkg;

	// Screen coordinates, 320x240
	typedef logic [8:0] x_coord_t;
	typedef logic [7:0] y_coord_t;

	// Negative is upward on screen
	typedef logic signed [9:0] velocity_t;

	typedef enum logic {
		RUNNING  = 1'b0,
		AIRBORNE = 1'b1
	} jump_state_e;

	typedef logic [15:0] score_t;

	// Active low, segment a in bit 0
	typedef logic [6:0] seg7_t;

endpackage

// File: hdl/uart_pkg.sv
package uart_pkg;

	// One byte off the serial line
	typedef logic [7:0] byte_t;

	// Receiver FSM
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,
		RX_START = 2'd1, // Waiting for mid start bit
		RX_DATA  = 2'd2,
		RX_STOP  = 2'd3
	} rx_state_e;

endpackage

// File: hdl/dino_runner_cfg.svh
`ifndef DINO_RUNNER_CFG_SVH
`define DINO_RUNNER_CFG_SVH

// Clock and serial link, 27 clocks per 16x tick
`define DR_CLK_HZ 50000000
`define DR_BAUD 115200

// Game tick, kept short for simulation
`define DR_TICK_DIV 64

// Screen geometry in pixels
`define DR_XSCREEN 320
`define DR_BOX 32
`define DR_DINO_X 52
`define DR_GROUND_Y 119
`define DR_OBST_Y 114

// Jump physics, pixels per tick
`define DR_JUMP_FORCE 12
`define DR_GRAVITY 1

// Hitbox half-ranges
`define DR_HB_W 6
`define DR_HB_H 30

`define DR_RESPAWN_SPAN 100
`define DR_LFSR_SEED 16'hACE1

// ASCII "J"
`define DR_CMD_JUMP 8'h4A

`endif
